// File: gamma_pkg.sv
// Register map, widths, control bundle, write-data union and gamma table function
`default_nettype none

package gamma_pkg;

    localparam int reg_addr_w = 4;
    localparam int pixel_w    = 8;
    localparam int gamma_w    = 3;

    // Byte offsets, low nibble only
    localparam logic [reg_addr_w-1:0] addr_ctrl      = 4'h0;
    localparam logic [reg_addr_w-1:0] addr_gamma     = 4'h4;
    localparam logic [reg_addr_w-1:0] addr_pixel_in  = 4'h8;
    localparam logic [reg_addr_w-1:0] addr_pixel_out = 4'hC;

    localparam logic [1:0] resp_okay = 2'b00;

    // Settings handed from the register block to the core
    typedef struct packed {
        logic               enable;
        logic               clear;
        logic [gamma_w-1:0] gamma_factor;
        logic [pixel_w-1:0] pixel_in;
    } gamma_ctrl_t;

    typedef struct packed {
        logic [23:0] unused;
        logic [7:0]  low_byte;
    } wdata_fields_t;

    // One write word, seen whole or by its low byte
    typedef union packed {
        logic [31:0]   raw;
        wdata_fields_t fields;
    } wdata_u;

    function automatic logic [pixel_w-1:0] gamma_entry(input logic [gamma_w-1:0] factor,
                                                       input logic [pixel_w-1:0] pixel);
        int product;
        product = int'(pixel) * (int'(factor) + 1);
        // Wraps past 255
        return product[pixel_w-1:0];
    endfunction

endpackage

`default_nettype wire

// File: gamma_axi_regs.sv
// AXI4-Lite slave channels, control/gamma/pixel-in registers and read multiplexer
`timescale 1ns/100ps
`default_nettype none

module gamma_axi_regs
    import gamma_pkg::*;
(
    input  logic               s_axi_aclk,
    input  logic               s_axi_aresetn,

    input  logic [31:0]        s_axi_awaddr,
    input  logic [2:0]         s_axi_awprot,
    input  logic               s_axi_awvalid,
    output logic               s_axi_awready,

    input  logic [31:0]        s_axi_wdata,
    input  logic [3:0]         s_axi_wstrb,
    input  logic               s_axi_wvalid,
    output logic               s_axi_wready,

    output logic [1:0]         s_axi_bresp,
    output logic               s_axi_bvalid,
    input  logic               s_axi_bready,

    input  logic [31:0]        s_axi_araddr,
    input  logic [2:0]         s_axi_arprot,
    input  logic               s_axi_arvalid,
    output logic               s_axi_arready,

    output logic [31:0]        s_axi_rdata,
    output logic [1:0]         s_axi_rresp,
    output logic               s_axi_rvalid,
    input  logic               s_axi_rready,

    output gamma_ctrl_t        ctrl,
    input  logic [pixel_w-1:0] pixel_out
);

    // awprot and arprot carry no meaning for this block

    logic [reg_addr_w-1:0] aw_addr;
    logic                  aw_held;
    logic                  aw_take;
    logic                  wr_fire;
    logic [reg_addr_w-1:0] ar_addr;
    logic                  ar_take;
    logic                  rd_fire;
    wdata_u                wdata;
    logic [31:0]           rd_word;

    assign wdata.raw = s_axi_wdata;

    assign aw_take = !s_axi_awready && s_axi_awvalid && !aw_held;
    assign wr_fire = s_axi_wready && s_axi_wvalid;
    assign ar_take = !s_axi_arready && s_axi_arvalid && !s_axi_rvalid;
    assign rd_fire = s_axi_arready && s_axi_arvalid && !s_axi_rvalid;

    assign s_axi_bresp = resp_okay;
    assign s_axi_rresp = resp_okay;

    // Write address, one-cycle ready pulse
    always_ff @(posedge s_axi_aclk) begin
        if (!s_axi_aresetn) begin
            s_axi_awready <= 1'b0;
            aw_held       <= 1'b0;
        end else if (aw_take) begin
            s_axi_awready <= 1'b1;
            aw_held       <= 1'b1;
        end else begin
            s_axi_awready <= 1'b0;
            if (wr_fire) begin
                aw_held <= 1'b0;
            end
        end
    end

    always_ff @(posedge s_axi_aclk) begin
        if (aw_take) begin
            aw_addr <= s_axi_awaddr[reg_addr_w-1:0];
        end
    end

    // Data is taken only once the address is in hand
    always_ff @(posedge s_axi_aclk) begin
        if (!s_axi_aresetn) begin
            s_axi_wready <= 1'b0;
        end else begin
            s_axi_wready <= !s_axi_wready && s_axi_wvalid && aw_held && !s_axi_bvalid;
        end
    end

    always_ff @(posedge s_axi_aclk) begin
        if (!s_axi_aresetn) begin
            s_axi_bvalid <= 1'b0;
        end else if (wr_fire) begin
            s_axi_bvalid <= 1'b1;
        end else if (s_axi_bvalid && s_axi_bready) begin
            s_axi_bvalid <= 1'b0;
        end
    end

    // Each register picks its field from the same low byte
    always_ff @(posedge s_axi_aclk) begin
        if (!s_axi_aresetn) begin
            ctrl <= '0;
        end else if (wr_fire && s_axi_wstrb[0]) begin
            case (aw_addr)
                addr_ctrl: begin
                    ctrl.enable <= wdata.fields.low_byte[0];
                    ctrl.clear  <= wdata.fields.low_byte[1];
                end
                addr_gamma: begin
                    ctrl.gamma_factor <= wdata.fields.low_byte[gamma_w-1:0];
                end
                addr_pixel_in: begin
                    ctrl.pixel_in <= wdata.fields.low_byte;
                end
                default: begin
                end
            endcase
        end
    end

    // Read address, held off while a response is pending
    always_ff @(posedge s_axi_aclk) begin
        if (!s_axi_aresetn) begin
            s_axi_arready <= 1'b0;
        end else begin
            s_axi_arready <= ar_take;
        end
    end

    always_ff @(posedge s_axi_aclk) begin
        if (ar_take) begin
            ar_addr <= s_axi_araddr[reg_addr_w-1:0];
        end
    end

    always_comb begin
        rd_word = '0;
        case (ar_addr)
            addr_ctrl:      rd_word[1:0] = {ctrl.clear, ctrl.enable};
            addr_gamma:     rd_word[gamma_w-1:0] = ctrl.gamma_factor;
            addr_pixel_in:  rd_word[pixel_w-1:0] = ctrl.pixel_in;
            addr_pixel_out: rd_word[pixel_w-1:0] = pixel_out;
            default:        rd_word = '0;
        endcase
    end

    always_ff @(posedge s_axi_aclk) begin
        if (!s_axi_aresetn) begin
            s_axi_rvalid <= 1'b0;
        end else if (rd_fire) begin
            s_axi_rvalid <= 1'b1;
        end else if (s_axi_rvalid && s_axi_rready) begin
            s_axi_rvalid <= 1'b0;
        end
    end

    always_ff @(posedge s_axi_aclk) begin
        if (rd_fire) begin
            s_axi_rdata <= rd_word;
        end
    end

endmodule

`default_nettype wire

// File: gamma_core.sv
// Gamma lookup table and registered pixel-out stage with enable and clear
`timescale 1ns/100ps
`default_nettype none

module gamma_core
    import gamma_pkg::*;
(
    input  logic               s_axi_aclk,
    input  logic               s_axi_aresetn,
    input  gamma_ctrl_t        ctrl,
    output logic [pixel_w-1:0] pixel_out
);

    logic [pixel_w-1:0] gamma_lut [2**gamma_w][2**pixel_w];
    logic [pixel_w-1:0] lut_value;

    // Constant table, one row per gamma factor
    for (genvar g = 0; g < 2**gamma_w; g++) begin : g_row
        for (genvar p = 0; p < 2**pixel_w; p++) begin : g_col
            assign gamma_lut[g][p] = gamma_entry(gamma_w'(g), pixel_w'(p));
        end
    end

    assign lut_value = gamma_lut[ctrl.gamma_factor][ctrl.pixel_in];

    // Clear wins over enable
    always_ff @(posedge s_axi_aclk) begin
        if (!s_axi_aresetn) begin
            pixel_out <= '0;
        end else if (ctrl.clear) begin
            pixel_out <= '0;
        end else if (ctrl.enable) begin
            pixel_out <= lut_value;
        end
    end

endmodule

`default_nettype wire

// File: gamma_correction_codec.sv
// Top level: AXI4-Lite register block wired to the gamma correction core
`timescale 1ns/100ps
`default_nettype none

module gamma_correction_codec
    import gamma_pkg::*;
(
    input  logic        s_axi_aclk,
    input  logic        s_axi_aresetn,

    input  logic [31:0] s_axi_awaddr,
    input  logic [2:0]  s_axi_awprot,
    input  logic        s_axi_awvalid,
    output logic        s_axi_awready,

    input  logic [31:0] s_axi_wdata,
    input  logic [3:0]  s_axi_wstrb,
    input  logic        s_axi_wvalid,
    output logic        s_axi_wready,

    output logic [1:0]  s_axi_bresp,
    output logic        s_axi_bvalid,
    input  logic        s_axi_bready,

    input  logic [31:0] s_axi_araddr,
    input  logic [2:0]  s_axi_arprot,
    input  logic        s_axi_arvalid,
    output logic        s_axi_arready,

    output logic [31:0] s_axi_rdata,
    output logic [1:0]  s_axi_rresp,
    output logic        s_axi_rvalid,
    input  logic        s_axi_rready
);

    // Levels between the blocks, sampled every clock
    gamma_ctrl_t        ctrl;
    logic [pixel_w-1:0] pixel_out;

    // Bus ports share names with the top, so they connect implicitly
    gamma_axi_regs u_regs (
        .*
    );

    gamma_core u_core (
        .s_axi_aclk    (s_axi_aclk),
        .s_axi_aresetn (s_axi_aresetn),
        .ctrl          (ctrl),
        .pixel_out     (pixel_out)
    );

endmodule

`default_nettype wire

// File: gamma_props.sv
// Concurrent assertions on the AXI4-Lite channels of the register block
`timescale 1ns/100ps
`default_nettype none

module gamma_props (
    input logic s_axi_aclk,
    input logic s_axi_aresetn,
    input logic s_axi_awready,
    input logic s_axi_wready,
    input logic aw_held,
    input logic s_axi_bvalid,
    input logic s_axi_bready,
    input logic s_axi_rvalid,
    input logic s_axi_rready
);

    awready_one_cycle: assert property (@(posedge s_axi_aclk) disable iff (!s_axi_aresetn)
        s_axi_awready |=> !s_axi_awready)
        else $error("awready stayed high for two cycles");

    wready_needs_address: assert property (@(posedge s_axi_aclk) disable iff (!s_axi_aresetn)
        s_axi_wready |-> aw_held)
        else $error("wready high without a held write address");

    bvalid_held: assert property (@(posedge s_axi_aclk) disable iff (!s_axi_aresetn)
        (s_axi_bvalid && !s_axi_bready) |=> s_axi_bvalid)
        else $error("bvalid dropped before bready");

    rvalid_held: assert property (@(posedge s_axi_aclk) disable iff (!s_axi_aresetn)
        (s_axi_rvalid && !s_axi_rready) |=> s_axi_rvalid)
        else $error("rvalid dropped before rready");

endmodule

`default_nettype wire

// File: tb_clkgen.sv
// Testbench clock and reset generator
`timescale 1ns/100ps
`default_nettype none

module tb_clkgen (
    output logic s_axi_aclk,
    output logic s_axi_aresetn
);

    // 20 ns period
    initial begin
        s_axi_aclk = 1'b0;
        forever #10 s_axi_aclk = ~s_axi_aclk;
    end

    // Reset held low over the first 3 rising edges
    initial begin
        s_axi_aresetn = 1'b0;
        repeat (3) @(posedge s_axi_aclk);
        #1;
        s_axi_aresetn = 1'b1;
    end

endmodule

`default_nettype wire

// File: tb_gamma_correction_codec.sv
// Table-driven testbench with bus tasks, compare tasks, reference model and watchdog
`timescale 1ns/100ps
`default_nettype none

module tb_gamma_correction_codec
    import gamma_pkg::*;
;

    localparam logic [31:0] base_addr    = 32'h4000_0000;
    localparam int          reset_cycles = 3;

    typedef struct packed {
        logic                  is_write;
        logic [reg_addr_w-1:0] offset;
        logic [3:0]            strb;
        wdata_u                data;
        logic [31:0]           expected;
    } bus_op_t;

    logic        s_axi_aclk;
    logic        s_axi_aresetn;
    logic [31:0] s_axi_awaddr;
    logic [2:0]  s_axi_awprot;
    logic        s_axi_awvalid;
    logic        s_axi_awready;
    logic [31:0] s_axi_wdata;
    logic [3:0]  s_axi_wstrb;
    logic        s_axi_wvalid;
    logic        s_axi_wready;
    logic [1:0]  s_axi_bresp;
    logic        s_axi_bvalid;
    logic        s_axi_bready;
    logic [31:0] s_axi_araddr;
    logic [2:0]  s_axi_arprot;
    logic        s_axi_arvalid;
    logic        s_axi_arready;
    logic [31:0] s_axi_rdata;
    logic [1:0]  s_axi_rresp;
    logic        s_axi_rvalid;
    logic        s_axi_rready;

    bus_op_t ops[$];
    int      table_len   = 0;
    int      data_errors = 0;
    int      resp_errors = 0;

    // Register model used to derive expected read values
    logic               m_enable;
    logic               m_clear;
    logic [gamma_w-1:0] m_gamma;
    logic [pixel_w-1:0] m_pixel_in;
    logic [pixel_w-1:0] m_pixel_out;

    tb_clkgen u_clkgen (
        .s_axi_aclk    (s_axi_aclk),
        .s_axi_aresetn (s_axi_aresetn)
    );

    gamma_correction_codec u_dut (
        .*
    );

    bind gamma_axi_regs gamma_props u_props (
        .s_axi_aclk    (s_axi_aclk),
        .s_axi_aresetn (s_axi_aresetn),
        .s_axi_awready (s_axi_awready),
        .s_axi_wready  (s_axi_wready),
        .aw_held       (aw_held),
        .s_axi_bvalid  (s_axi_bvalid),
        .s_axi_bready  (s_axi_bready),
        .s_axi_rvalid  (s_axi_rvalid),
        .s_axi_rready  (s_axi_rready)
    );

    task automatic check_resp(input logic [1:0] got, input string what);
        if (got !== resp_okay) begin
            resp_errors++;
            $display("[ERROR] %0t: %s response 0x%h, expected OKAY", $time, what, got);
        end
    endtask

    task automatic check_data(input logic [31:0] got, input logic [31:0] expected,
                              input logic [reg_addr_w-1:0] offset);
        if (got !== expected) begin
            data_errors++;
            $display("[ERROR] %0t: read of offset 0x%h returned 0x%h, expected 0x%h",
                     $time, offset, got, expected);
        end
    endtask

    // Pixel summed gamma plus one times in an 8-bit accumulator
    function automatic logic [pixel_w-1:0] scaled_pixel(input logic [gamma_w-1:0] factor,
                                                        input logic [pixel_w-1:0] pixel);
        logic [pixel_w-1:0] acc;
        acc = pixel;
        for (int k = 0; k < int'(factor); k++) begin
            acc = acc + pixel;
        end
        return acc;
    endfunction

    // Core output after the registers settle
    task automatic settle_model();
        if (m_clear) begin
            m_pixel_out = '0;
        end else if (m_enable) begin
            m_pixel_out = scaled_pixel(m_gamma, m_pixel_in);
        end
    endtask

    task automatic add_write(input logic [reg_addr_w-1:0] offset, input logic [3:0] strb,
                             input logic [23:0] upper, input logic [7:0] low);
        bus_op_t op;
        op.is_write             = 1'b1;
        op.offset               = offset;
        op.strb                 = strb;
        op.data.fields.unused   = upper;
        op.data.fields.low_byte = low;
        op.expected             = '0;
        ops.push_back(op);
        if (strb[0]) begin
            case (offset)
                addr_ctrl: begin
                    m_enable = low[0];
                    m_clear  = low[1];
                end
                addr_gamma:    m_gamma    = low[gamma_w-1:0];
                addr_pixel_in: m_pixel_in = low;
                default: begin
                end
            endcase
        end
        settle_model();
    endtask

    task automatic add_read(input logic [reg_addr_w-1:0] offset);
        bus_op_t op;
        op.is_write = 1'b0;
        op.offset   = offset;
        op.strb     = '0;
        op.data.raw = '0;
        case (offset)
            addr_ctrl:      op.expected = {30'd0, m_clear, m_enable};
            addr_gamma:     op.expected = {29'd0, m_gamma};
            addr_pixel_in:  op.expected = {24'd0, m_pixel_in};
            addr_pixel_out: op.expected = {24'd0, m_pixel_out};
            default:        op.expected = '0;
        endcase
        ops.push_back(op);
    endtask

    task automatic build_table();
        logic [gamma_w-1:0] rnd_gamma;
        logic [pixel_w-1:0] rnd_pixel;
        m_enable    = 1'b0;
        m_clear     = 1'b0;
        m_gamma     = '0;
        m_pixel_in  = '0;
        m_pixel_out = '0;
        add_read(addr_ctrl);
        add_read(addr_gamma);
        add_read(addr_pixel_in);
        add_read(addr_pixel_out);
        // Upper bits set and only the field widths read back
        add_write(addr_ctrl, 4'hF, 24'hFFFFFF, 8'hFF);
        add_write(addr_gamma, 4'hF, 24'hFFFFFF, 8'hFF);
        add_write(addr_pixel_in, 4'hF, 24'hA5A5A5, 8'hA5);
        add_read(addr_ctrl);
        add_read(addr_gamma);
        add_read(addr_pixel_in);
        add_read(addr_pixel_out);
        add_write(addr_ctrl, 4'hF, 24'h0, 8'h01);
        add_read(addr_pixel_out);
        add_write(addr_gamma, 4'hF, 24'h0, 8'h03);
        add_write(addr_pixel_in, 4'hF, 24'h0, 8'hC8);
        add_read(addr_pixel_out);
        add_write(addr_gamma, 4'hF, 24'h0, 8'h00);
        add_write(addr_pixel_in, 4'hF, 24'h0, 8'hFF);
        add_read(addr_pixel_out);
        for (int i = 0; i < 6; i++) begin
            rnd_gamma = gamma_w'($urandom_range(7, 0));
            rnd_pixel = pixel_w'($urandom_range(255, 0));
            add_write(addr_gamma, 4'hF, 24'h0, {5'd0, rnd_gamma});
            add_write(addr_pixel_in, 4'hF, 24'h0, rnd_pixel);
            add_read(addr_pixel_out);
        end
        // Disabled core holds its last pixel
        add_write(addr_ctrl, 4'hF, 24'h0, 8'h00);
        add_write(addr_pixel_in, 4'hF, 24'h0, 8'h5B);
        add_read(addr_pixel_out);
        add_write(addr_ctrl, 4'hF, 24'h0, 8'h02);
        add_read(addr_pixel_out);
        add_write(addr_ctrl, 4'hF, 24'h0, 8'h03);
        add_read(addr_ctrl);
        add_read(addr_pixel_out);
        add_write(addr_ctrl, 4'hF, 24'h0, 8'h01);
        add_read(addr_pixel_out);
        // Strobe bit 0 low and then unmapped offsets
        add_write(addr_pixel_in, 4'hE, 24'h0, 8'h11);
        add_read(addr_pixel_in);
        add_read(addr_pixel_out);
        add_read(4'h3);
        add_read(4'hE);
    endtask

    task automatic write_reg(input logic [reg_addr_w-1:0] offset, input logic [3:0] strb,
                             input wdata_u data);
        @(posedge s_axi_aclk);
        #1;
        s_axi_awaddr  = base_addr | 32'(offset);
        s_axi_awvalid = 1'b1;
        s_axi_wdata   = data.raw;
        s_axi_wstrb   = strb;
        s_axi_wvalid  = 1'b1;
        @(posedge s_axi_aclk);
        #1;
        while (!s_axi_awready) begin
            @(posedge s_axi_aclk);
            #1;
        end
        @(posedge s_axi_aclk);
        #1;
        s_axi_awvalid = 1'b0;
        while (!s_axi_wready) begin
            @(posedge s_axi_aclk);
            #1;
        end
        @(posedge s_axi_aclk);
        #1;
        s_axi_wvalid = 1'b0;
        while (!s_axi_bvalid) begin
            @(posedge s_axi_aclk);
            #1;
        end
        // One cycle of back-pressure on the response
        @(posedge s_axi_aclk);
        #1;
        check_resp(s_axi_bresp, "write");
        s_axi_bready = 1'b1;
        @(posedge s_axi_aclk);
        #1;
        s_axi_bready = 1'b0;
    endtask

    task automatic read_reg(input logic [reg_addr_w-1:0] offset, output logic [31:0] data,
                            output logic [1:0] resp);
        @(posedge s_axi_aclk);
        #1;
        s_axi_araddr  = base_addr | 32'(offset);
        s_axi_arvalid = 1'b1;
        @(posedge s_axi_aclk);
        #1;
        while (!s_axi_arready) begin
            @(posedge s_axi_aclk);
            #1;
        end
        @(posedge s_axi_aclk);
        #1;
        s_axi_arvalid = 1'b0;
        while (!s_axi_rvalid) begin
            @(posedge s_axi_aclk);
            #1;
        end
        @(posedge s_axi_aclk);
        #1;
        data = s_axi_rdata;
        resp = s_axi_rresp;
        s_axi_rready = 1'b1;
        @(posedge s_axi_aclk);
        #1;
        s_axi_rready = 1'b0;
    endtask

    initial begin : watchdog
        wait (table_len > 0);
        repeat (table_len * 20 + reset_cycles) @(posedge s_axi_aclk);
        $display("Run timed out: the bus sequence did not finish in time");
        $display("=== FAIL ===");
        $finish;
    end

    initial begin : stimulus
        logic [31:0] rd_data;
        logic [1:0]  rd_resp;
        s_axi_awaddr  = '0;
        s_axi_awprot  = '0;
        s_axi_awvalid = 1'b0;
        s_axi_wdata   = '0;
        s_axi_wstrb   = '0;
        s_axi_wvalid  = 1'b0;
        s_axi_bready  = 1'b0;
        s_axi_araddr  = '0;
        s_axi_arprot  = '0;
        s_axi_arvalid = 1'b0;
        s_axi_rready  = 1'b0;
        void'($urandom(56955));
        build_table();
        table_len = ops.size();
        wait (s_axi_aresetn);
        @(posedge s_axi_aclk);
        foreach (ops[i]) begin
            if (ops[i].is_write) begin
                write_reg(ops[i].offset, ops[i].strb, ops[i].data);
            end else begin
                read_reg(ops[i].offset, rd_data, rd_resp);
                check_resp(rd_resp, "read");
                check_data(rd_data, ops[i].expected, ops[i].offset);
            end
        end
        $display("Summary: %0d data errors, %0d response errors over %0d operations",
                 data_errors, resp_errors, table_len);
        if (data_errors == 0 && resp_errors == 0) begin
            $display("=== PASS ===");
        end else begin
            $display("=== FAIL ===");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: gamma_correction_codec.f
gamma_pkg.sv
gamma_axi_regs.sv
gamma_core.sv
gamma_correction_codec.sv
gamma_props.sv
tb_clkgen.sv
tb_gamma_correction_codec.sv

// File: Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0
TOP       ?= tb_gamma_correction_codec
FILELIST  ?= gamma_correction_codec.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator and run the simulation"
	@echo "  clean  remove the build directory and the log"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if [ $$status -ne 0 ] || grep -q "=== FAIL ===" $(LOG); then \
		echo "Simulation failed"; exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)
